// File: src/jtag_mem_pkg.sv
/* JTAG byte memory shared definitions */

package jtag_mem_pkg;

    localparam int DATA_WIDTH = 8;  // Memory and JTAG data width

    // JTAG instruction register codes
    typedef enum logic [1:0] {
        IR_BYPASS   = 2'b00,
        IR_WRITE    = 2'b01,
        IR_READ     = 2'b10,
        IR_SET_ADDR = 2'b11
    } ir_t;

    // Controller FSM states
    typedef enum logic [2:0] {
        IDLE,
        SET_ADDR,
        WAIT_SET_ADDR,
        WRITE,
        WAIT_WRITE,
        READ,
        WAIT_READ
    } ctrl_state_t;

    // Active-low segments, bit order gfedcba
    localparam logic [6:0] SEG_R     = 7'b0101111;
    localparam logic [6:0] SEG_D     = 7'b0100001;
    localparam logic [6:0] SEG_A     = 7'b0001000;
    localparam logic [6:0] SEG_J     = 7'b1100001;
    localparam logic [6:0] SEG_BLANK = 7'b1111111;

    // Hex digits 0 to F
    localparam logic [6:0] SEG_HEX [16] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
        7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
        7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
        7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
    };

endpackage

// File: src/jtag_cmd_sync.sv
/* JTAG command synchronizer */
`timescale 1ns/1ps

module jtag_cmd_sync #(
    parameter int ADDR_WIDTH = 18
) (
    input  logic                                clk,
    input  logic                                rst,
    input  jtag_mem_pkg::ir_t                   jtag_ir,
    input  logic                                jtag_udr,
    input  logic [jtag_mem_pkg::DATA_WIDTH-1:0] jtag_wdata,
    input  logic [ADDR_WIDTH-1:0]               jtag_addr,
    output logic                                cmd_valid,
    output jtag_mem_pkg::ir_t                   cmd_ir,
    output logic [jtag_mem_pkg::DATA_WIDTH-1:0] cmd_data,
    output logic [ADDR_WIDTH-1:0]               cmd_addr
);
    import jtag_mem_pkg::*;

    ir_t                   ir_meta;
    logic [DATA_WIDTH-1:0] data_meta;
    logic [ADDR_WIDTH-1:0] addr_meta;
    logic                  udr_meta;
    logic                  udr_sync;
    logic                  udr_prev;   // Extra stage for edge detect

    // Update-DR path, the only one that qualifies a command
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            udr_meta <= 1'b0;
            udr_sync <= 1'b0;
            udr_prev <= 1'b0;
        end else begin
            udr_meta <= jtag_udr;
            udr_sync <= udr_meta;
            udr_prev <= udr_sync;
        end
    end

    // Buses are held steady by the host around Update-DR
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ir_meta   <= IR_BYPASS;
            cmd_ir    <= IR_BYPASS;
            data_meta <= '0;
            cmd_data  <= '0;
            addr_meta <= '0;
            cmd_addr  <= '0;
        end else begin
            ir_meta   <= jtag_ir;
            cmd_ir    <= ir_meta;
            data_meta <= jtag_wdata;
            cmd_data  <= data_meta;
            addr_meta <= jtag_addr;
            cmd_addr  <= addr_meta;
        end
    end

    assign cmd_valid = udr_sync & ~udr_prev;  // Rising edge strobe

endmodule

// File: src/jtag_mem_ctrl.sv
/* JTAG memory command controller */
`timescale 1ns/1ps

module jtag_mem_ctrl #(
    parameter int ADDR_WIDTH = 18
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                cmd_valid,
    input  jtag_mem_pkg::ir_t                   cmd_ir,
    input  logic [jtag_mem_pkg::DATA_WIDTH-1:0] cmd_data,
    input  logic [ADDR_WIDTH-1:0]               cmd_addr,
    input  logic [jtag_mem_pkg::DATA_WIDTH-1:0] ram_rdata,
    output logic [ADDR_WIDTH-1:0]               ram_addr,
    output logic [jtag_mem_pkg::DATA_WIDTH-1:0] ram_wdata,
    output logic                                ram_we,
    output logic                                ram_own,
    output logic                                jtag_busy,
    output logic [ADDR_WIDTH-1:0]               last_addr,
    output logic [jtag_mem_pkg::DATA_WIDTH-1:0] last_data
);
    import jtag_mem_pkg::*;

    ctrl_state_t           state;
    ctrl_state_t           state_nxt;
    logic                  start;    // Strobe accepted only in IDLE
    logic [ADDR_WIDTH-1:0] addr_q;   // Last SET_ADDR target
    logic [DATA_WIDTH-1:0] data_q;   // Last written or read byte

    assign start = cmd_valid && (state == IDLE);

    // ========================================================================
    // Next state
    // ========================================================================
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (start) begin
                    case (cmd_ir)
                        IR_SET_ADDR: state_nxt = SET_ADDR;
                        IR_WRITE:    state_nxt = WRITE;
                        IR_READ:     state_nxt = READ;
                        default:     state_nxt = IDLE;   // Bypass
                    endcase
                end
            end
            SET_ADDR:      state_nxt = WAIT_SET_ADDR;
            WAIT_SET_ADDR: state_nxt = IDLE;
            WRITE:         state_nxt = WAIT_WRITE;   // Write strobe here
            WAIT_WRITE:    state_nxt = IDLE;
            READ:          state_nxt = WAIT_READ;    // Address at RAM
            WAIT_READ:     state_nxt = IDLE;         // Read data valid
            default:       state_nxt = IDLE;
        endcase
    end

    // ========================================================================
    // State and command registers
    // ========================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= IDLE;
            addr_q <= '0;
            data_q <= '0;
        end else begin
            state <= state_nxt;
            if (start && cmd_ir == IR_SET_ADDR)
                addr_q <= cmd_addr;
            if (start && cmd_ir == IR_WRITE)
                data_q <= cmd_data;
            if (state == WAIT_READ)
                data_q <= ram_rdata;          // One cycle RAM latency
        end
    end

    assign ram_addr  = addr_q;
    assign ram_wdata = data_q;
    assign last_addr = addr_q;
    assign last_data = data_q;

    assign ram_we    = (state == WRITE);
    assign ram_own   = (state inside {WRITE, WAIT_WRITE, READ, WAIT_READ});
    assign jtag_busy = (state != IDLE);

endmodule

// File: src/key_debounce.sv
/* Key debouncer */
`timescale 1ns/1ps

module key_debounce #(
    parameter int DEBOUNCE_CYCLES = 500000
) (
    input  logic clk,
    input  logic rst,
    input  logic key_n,
    output logic press
);

    localparam int CNT_W = (DEBOUNCE_CYCLES > 0) ? $clog2(DEBOUNCE_CYCLES + 1) : 1;

    logic             key_meta;
    logic             key_sync;
    logic             key_stable;   // Debounced level
    logic             key_prev;
    logic [CNT_W-1:0] cnt;          // Cycles differing from stable

    // Two-flop synchronizer, idle high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key_meta <= 1'b1;
            key_sync <= 1'b1;
        end else begin
            key_meta <= key_n;
            key_sync <= key_meta;
        end
    end

    // Stability counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt        <= '0;
            key_stable <= 1'b1;
            key_prev   <= 1'b1;
        end else begin
            key_prev <= key_stable;
            if (key_sync == key_stable) begin
                cnt <= '0;                          // Bounce restarts count
            end else if (cnt == CNT_W'(DEBOUNCE_CYCLES)) begin
                key_stable <= key_sync;             // Settled
                cnt        <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign press = key_prev & ~key_stable;  // Stable high to low

endmodule

// File: src/view_addr_nav.sv
/* Viewing address navigation */
`timescale 1ns/1ps

module view_addr_nav #(
    parameter int ADDR_WIDTH      = 18,
    parameter int DEBOUNCE_CYCLES = 500000
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  key_up_n,
    input  logic                  key_down_n,
    output logic [ADDR_WIDTH-1:0] view_addr
);

    logic up_press;
    logic down_press;

    key_debounce #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_key_up (
        .clk   (clk),
        .rst   (rst),
        .key_n (key_up_n),
        .press (up_press)
    );

    key_debounce #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_key_down (
        .clk   (clk),
        .rst   (rst),
        .key_n (key_down_n),
        .press (down_press)
    );

    // Saturating step, up wins
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            view_addr <= '0;
        end else if (up_press) begin
            if (view_addr != '1)
                view_addr <= view_addr + 1'b1;   // Stop at top of memory
        end else if (down_press) begin
            if (view_addr != '0)
                view_addr <= view_addr - 1'b1;   // Stop at zero
        end
    end

endmodule

// File: src/byte_ram.sv
/* Synchronous byte RAM */
`timescale 1ns/1ps

module byte_ram #(
    parameter int ADDR_WIDTH = 18
) (
    input  logic                                clk,
    input  logic [ADDR_WIDTH-1:0]               addr,
    input  logic [jtag_mem_pkg::DATA_WIDTH-1:0] wdata,
    input  logic                                we,
    output logic [jtag_mem_pkg::DATA_WIDTH-1:0] rdata
);
    import jtag_mem_pkg::*;

    logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

    // Power-up contents
    initial mem = '{default: '0};

    // Read before write on a shared address
    always_ff @(posedge clk) begin
        if (we)
            mem[addr] <= wdata;
        rdata <= mem[addr];    // Old data on same-address write
    end

endmodule

// File: src/seg_display.sv
/* Seven-segment display selection */
`timescale 1ns/1ps

module seg_display #(
    parameter int ADDR_WIDTH = 18
) (
    input  logic                                view_jtag,      // 0 read view, 1 JTAG view
    input  logic                                view_addr_sel,  // 0 data, 1 address
    input  logic [ADDR_WIDTH-1:0]               read_addr,
    input  logic [jtag_mem_pkg::DATA_WIDTH-1:0] read_data,
    input  logic [ADDR_WIDTH-1:0]               jtag_addr,
    input  logic [jtag_mem_pkg::DATA_WIDTH-1:0] jtag_data,
    output logic [6:0]                          hex0,
    output logic [6:0]                          hex1,
    output logic [6:0]                          hex2,
    output logic [6:0]                          hex3,
    output logic [6:0]                          hex4,
    output logic [6:0]                          hex5
);
    import jtag_mem_pkg::*;

    // Room for at least four digits
    localparam int VW = (ADDR_WIDTH > 16) ? ADDR_WIDTH : 16;

    logic [VW-1:0]         addr_ext;
    logic [DATA_WIDTH-1:0] data_sel;
    logic [15:0]           value;    // Shown on hex5..hex2

    // ========================================================================
    // Value selection
    // ========================================================================
    always_comb begin
        addr_ext = view_jtag ? VW'(jtag_addr) : VW'(read_addr);
        data_sel = view_jtag ? jtag_data : read_data;
        value    = view_addr_sel ? addr_ext[15:0] : 16'(data_sel);  // Data as 00xx
    end

    assign hex5 = SEG_HEX[value[15:12]];
    assign hex4 = SEG_HEX[value[11:8]];
    assign hex3 = SEG_HEX[value[7:4]];
    assign hex2 = SEG_HEX[value[3:0]];

    // ========================================================================
    // Mode tag
    // ========================================================================
    always_comb begin
        case ({view_jtag, view_addr_sel})
            2'b00: begin hex1 = SEG_R; hex0 = SEG_D; end
            2'b01: begin hex1 = SEG_R; hex0 = SEG_A; end
            2'b10: begin hex1 = SEG_J; hex0 = SEG_D; end
            2'b11: begin hex1 = SEG_J; hex0 = SEG_A; end
            default: begin
                hex1 = SEG_BLANK;    // Unknown switch level
                hex0 = SEG_BLANK;
            end
        endcase
    end

endmodule

// File: src/jtag_mem_top.sv
/* JTAG byte memory top level */
`timescale 1ns/1ps

module jtag_mem_top #(
    parameter int ADDR_WIDTH      = 18,
    parameter int DEBOUNCE_CYCLES = 500000
) (
    input  logic                                clk,
    input  logic                                rst,
    input  jtag_mem_pkg::ir_t                   jtag_ir,
    input  logic                                jtag_udr,
    input  logic [jtag_mem_pkg::DATA_WIDTH-1:0] jtag_wdata,
    input  logic [ADDR_WIDTH-1:0]               jtag_addr,
    input  logic                                key_up_n,
    input  logic                                key_down_n,
    input  logic                                view_jtag,
    input  logic                                view_addr_sel,
    output logic [jtag_mem_pkg::DATA_WIDTH-1:0] jtag_rdata,
    output logic                                jtag_busy,    // Busy LED
    output logic [6:0]                          hex0,
    output logic [6:0]                          hex1,
    output logic [6:0]                          hex2,
    output logic [6:0]                          hex3,
    output logic [6:0]                          hex4,
    output logic [6:0]                          hex5
);
    import jtag_mem_pkg::*;

    logic                  cmd_valid;
    ir_t                   cmd_ir;
    logic [DATA_WIDTH-1:0] cmd_data;
    logic [ADDR_WIDTH-1:0] cmd_addr;
    logic [ADDR_WIDTH-1:0] ctrl_addr;
    logic [ADDR_WIDTH-1:0] last_addr;
    logic [ADDR_WIDTH-1:0] view_addr;
    logic [ADDR_WIDTH-1:0] ram_addr;
    logic [DATA_WIDTH-1:0] ram_wdata;
    logic [DATA_WIDTH-1:0] ram_rdata;
    logic [DATA_WIDTH-1:0] last_data;
    logic [DATA_WIDTH-1:0] view_data;   // Byte at the viewing address
    logic                  ram_we;
    logic                  ram_own;     // Controller holds the RAM port

    jtag_cmd_sync #(.ADDR_WIDTH(ADDR_WIDTH)) u_cmd_sync (
        .clk (clk), .rst (rst),
        .jtag_ir (jtag_ir), .jtag_udr (jtag_udr),
        .jtag_wdata (jtag_wdata), .jtag_addr (jtag_addr),
        .cmd_valid (cmd_valid), .cmd_ir (cmd_ir),
        .cmd_data (cmd_data), .cmd_addr (cmd_addr)
    );

    jtag_mem_ctrl #(.ADDR_WIDTH(ADDR_WIDTH)) u_ctrl (
        .clk (clk), .rst (rst),
        .cmd_valid (cmd_valid), .cmd_ir (cmd_ir),
        .cmd_data (cmd_data), .cmd_addr (cmd_addr),
        .ram_rdata (ram_rdata), .ram_addr (ctrl_addr),
        .ram_wdata (ram_wdata), .ram_we (ram_we),
        .ram_own (ram_own), .jtag_busy (jtag_busy),
        .last_addr (last_addr), .last_data (last_data)
    );

    view_addr_nav #(
        .ADDR_WIDTH      (ADDR_WIDTH),
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_nav (
        .clk (clk), .rst (rst),
        .key_up_n (key_up_n), .key_down_n (key_down_n),
        .view_addr (view_addr)
    );

    // ========================================================================
    // RAM port sharing
    // ========================================================================
    assign ram_addr = ram_own ? ctrl_addr : view_addr;   // JTAG first

    byte_ram #(.ADDR_WIDTH(ADDR_WIDTH)) u_ram (
        .clk (clk), .addr (ram_addr),
        .wdata (ram_wdata), .we (ram_we),
        .rdata (ram_rdata)
    );

    // Track the viewing address while the port is free
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            view_data <= '0;
        else if (!ram_own)
            view_data <= ram_rdata;
    end

    assign jtag_rdata = last_data;   // Captured in WAIT_READ

    seg_display #(.ADDR_WIDTH(ADDR_WIDTH)) u_disp (
        .view_jtag (view_jtag), .view_addr_sel (view_addr_sel),
        .read_addr (view_addr), .read_data (view_data),
        .jtag_addr (last_addr), .jtag_data (last_data),
        .hex0 (hex0), .hex1 (hex1), .hex2 (hex2),
        .hex3 (hex3), .hex4 (hex4), .hex5 (hex5)
    );

endmodule

// File: sim/jtag_mem_properties.sv
/* Controller assertions */
`timescale 1ns/1ps

module jtag_mem_properties (
    input logic                      clk,
    input logic                      rst,
    input jtag_mem_pkg::ctrl_state_t state,
    input logic                      ram_we,
    input logic                      ram_own
);
    import jtag_mem_pkg::*;

    // ========================================================================
    // Write strobe and state sequencing
    // ========================================================================

    // Single-cycle write strobe
    a_we_single: assert property (
        @(posedge clk) disable iff (rst)
        ram_we |=> !ram_we
    ) else $error("ram_we high on two consecutive cycles");

    // No run of busy states longer than two cycles
    a_idle_return: assert property (
        @(posedge clk) disable iff (rst)
        (state != IDLE && $past(state) != IDLE) |=> (state == IDLE)
    ) else $error("controller did not return to IDLE within two cycles");

    // Writes only while the controller holds the RAM port
    a_we_own: assert property (
        @(posedge clk) disable iff (rst)
        ram_we |-> ram_own
    ) else $error("ram_we high without ram_own");

endmodule

// File: sim/tb_jtag_mem_top.sv
/* JTAG byte memory testbench */
`timescale 1ns/1ps

module tb_jtag_mem_top;
    import jtag_mem_pkg::*;

    localparam int ADDR_WIDTH      = 8;
    localparam int DEBOUNCE_CYCLES = 8;
    localparam int BUSY_LIMIT      = 40;                    // Cycles per busy edge
    localparam int DISP_LIMIT      = 12;                    // Cycles for display to settle
    localparam int KEY_HOLD        = DEBOUNCE_CYCLES + 12;  // Well past settle time

    logic                  clk;
    logic                  rst;
    ir_t                   jtag_ir;
    logic                  jtag_udr;
    logic [DATA_WIDTH-1:0] jtag_wdata;
    logic [ADDR_WIDTH-1:0] jtag_addr;
    logic                  key_up_n;
    logic                  key_down_n;
    logic                  view_jtag;
    logic                  view_addr_sel;
    logic [DATA_WIDTH-1:0] jtag_rdata;
    logic                  jtag_busy;
    logic [6:0]            hex0;
    logic [6:0]            hex1;
    logic [6:0]            hex2;
    logic [6:0]            hex3;
    logic [6:0]            hex4;
    logic [6:0]            hex5;

    logic [DATA_WIDTH-1:0] model [2**ADDR_WIDTH];   // Expected RAM contents
    logic [ADDR_WIDTH-1:0] addr_list [6];           // Addresses under test

    jtag_mem_top #(
        .ADDR_WIDTH      (ADDR_WIDTH),
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) dut0 (
        .clk (clk), .rst (rst),
        .jtag_ir (jtag_ir), .jtag_udr (jtag_udr),
        .jtag_wdata (jtag_wdata), .jtag_addr (jtag_addr),
        .key_up_n (key_up_n), .key_down_n (key_down_n),
        .view_jtag (view_jtag), .view_addr_sel (view_addr_sel),
        .jtag_rdata (jtag_rdata), .jtag_busy (jtag_busy),
        .hex0 (hex0), .hex1 (hex1), .hex2 (hex2),
        .hex3 (hex3), .hex4 (hex4), .hex5 (hex5)
    );

    // Controller checks on every controller instance
    bind jtag_mem_ctrl jtag_mem_properties u_props (
        .clk (clk), .rst (rst), .state (state),
        .ram_we (ram_we), .ram_own (ram_own)
    );

    always #20 clk = ~clk;   // 40 ns period

    // ========================================================================
    // Reporting
    // ========================================================================
    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [15:0] got,
                                   input logic [15:0] exp);
        stop_on_error($sformatf("mismatch at %0t: %s is %h, expected %h",
                                $time, name, got, exp));
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got == exp) else report_mismatch(name, got, exp);
    endtask

    // ========================================================================
    // Display decoding, hex5 is the top digit
    // ========================================================================
    task automatic decode_display(output logic [15:0] val, output logic ok);
        logic [6:0] digits [4];
        logic       found;
        ok        = 1'b1;
        val       = '0;
        digits[0] = hex5;
        digits[1] = hex4;
        digits[2] = hex3;
        digits[3] = hex2;
        for (int d = 0; d < 4; d++) begin
            found = 1'b0;
            for (int n = 0; n < 16; n++) begin
                if (!found && digits[d] == SEG_HEX[n]) begin
                    val   = {val[11:0], 4'(n)};
                    found = 1'b1;
                end
            end
            if (!found)
                ok = 1'b0;     // Not a hex digit
        end
    endtask

    // Entered and left on a falling edge
    task automatic wait_display(input string name, input logic [15:0] exp);
        logic [15:0] val;
        logic        ok;
        decode_display(val, ok);
        for (int i = 0; i < DISP_LIMIT && !(ok && val == exp); i++) begin
            @(negedge clk);
            decode_display(val, ok);
        end
        assert (ok) else stop_on_error($sformatf(
            "%s shows a segment pattern that is not a hex digit", name));
        check_value(name, val, exp);
    endtask

    task automatic wait_busy(input logic level, input string what);
        for (int i = 0; i < BUSY_LIMIT && jtag_busy !== level; i++)
            @(negedge clk);
        if (jtag_busy !== level)
            stop_on_error($sformatf("timed out waiting for jtag_busy to go %0d during %s",
                                    level, what));
    endtask

    // ========================================================================
    // Stimulus
    // ========================================================================
    task automatic set_switches(input logic jtag_sel, input logic addr_sel);
        @(posedge clk);
        view_jtag     <= jtag_sel;
        view_addr_sel <= addr_sel;
        @(negedge clk);
    endtask

    // Buses first, then Update-DR held until the command is done
    task automatic jtag_command(input ir_t ir, input logic [ADDR_WIDTH-1:0] addr,
                                input logic [DATA_WIDTH-1:0] data, input string what);
        @(posedge clk);
        jtag_ir    <= ir;
        jtag_addr  <= addr;
        jtag_wdata <= data;
        repeat (2) @(posedge clk);
        jtag_udr <= 1'b1;
        @(negedge clk);
        wait_busy(1'b1, what);
        wait_busy(1'b0, what);
        @(posedge clk);
        jtag_udr <= 1'b0;
        repeat (4) @(negedge clk);   // Low level reaches the edge detector
    endtask

    task automatic press_key(input logic up, input int hold);
        @(posedge clk);
        if (up)
            key_up_n <= 1'b0;
        else
            key_down_n <= 1'b0;
        repeat (hold) @(posedge clk);
        key_up_n   <= 1'b1;
        key_down_n <= 1'b1;
        repeat (KEY_HOLD) @(posedge clk);    // Release settles too
        @(negedge clk);
    endtask

    task automatic check_view(input logic [ADDR_WIDTH-1:0] addr);
        set_switches(1'b0, 1'b1);
        wait_display("read view address", 16'(addr));
        set_switches(1'b0, 1'b0);
        wait_display("read view data", {8'h00, model[addr]});
    endtask

    task automatic check_tag(input logic jtag_sel, input logic addr_sel);
        set_switches(jtag_sel, addr_sel);
        check_value("hex1", 16'(hex1), 16'(jtag_sel ? SEG_J : SEG_R));
        check_value("hex0", 16'(hex0), 16'(addr_sel ? SEG_A : SEG_D));
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        logic [DATA_WIDTH-1:0] data;
        logic [ADDR_WIDTH-1:0] exp_addr;
        clk           = 1'b0;
        rst           = 1'b1;
        jtag_ir       = IR_BYPASS;
        jtag_udr      = 1'b0;
        jtag_wdata    = '0;
        jtag_addr     = '0;
        key_up_n      = 1'b1;   // Keys released
        key_down_n    = 1'b1;
        view_jtag     = 1'b0;
        view_addr_sel = 1'b0;
        void'($urandom(76));
        for (int a = 0; a < 2**ADDR_WIDTH; a++)
            model[a] = '0;
        addr_list = '{8'h00, 8'h01, 8'h02, 8'h03, 8'h7e, 8'hff};

        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        // Reset view
        check_tag(1'b0, 1'b0);
        wait_display("display after reset", 16'h0000);
        check_value("jtag_busy", 16'(jtag_busy), 16'h0000);

        // Writes through the JTAG side
        foreach (addr_list[i]) begin
            data = 8'($urandom);
            model[addr_list[i]] = data;
            jtag_command(IR_SET_ADDR, addr_list[i], 8'h00, "SET_ADDR");
            jtag_command(IR_WRITE, addr_list[i], data, "WRITE");
            set_switches(1'b1, 1'b1);
            wait_display("JTAG address view", 16'(addr_list[i]));
            set_switches(1'b1, 1'b0);
            wait_display("JTAG data view", {8'h00, data});
        end

        // Read back in write order, so each read replaces the last byte
        foreach (addr_list[i]) begin
            jtag_command(IR_SET_ADDR, addr_list[i], 8'h00, "SET_ADDR");
            jtag_command(IR_READ, addr_list[i], 8'h00, "READ");
            check_value("jtag_rdata", 16'(jtag_rdata), 16'(model[addr_list[i]]));
            set_switches(1'b1, 1'b0);
            wait_display("JTAG data view", {8'h00, model[addr_list[i]]});
        end

        // Key navigation of the read view
        exp_addr = '0;
        check_view(exp_addr);
        for (int n = 0; n < 3; n++) begin
            press_key(1'b1, KEY_HOLD);
            exp_addr = exp_addr + 1'b1;
            check_view(exp_addr);
        end
        press_key(1'b1, 4);                  // Bounce, too short
        check_view(exp_addr);
        press_key(1'b0, 4);
        check_view(exp_addr);
        for (int n = 0; n < 3; n++) begin
            press_key(1'b0, KEY_HOLD);
            exp_addr = exp_addr - 1'b1;
            check_view(exp_addr);
        end
        for (int n = 0; n < 2; n++) begin
            press_key(1'b0, KEY_HOLD);       // Saturates at zero
            check_view('0);
        end

        // Mode tags
        check_tag(1'b0, 1'b0);
        check_tag(1'b0, 1'b1);
        check_tag(1'b1, 1'b0);
        check_tag(1'b1, 1'b1);

        $display("All tests passed");
        $finish;
    end

endmodule

// File: vlog.f
src/jtag_mem_pkg.sv
src/jtag_cmd_sync.sv
src/jtag_mem_ctrl.sv
src/key_debounce.sv
src/view_addr_nav.sv
src/byte_ram.sv
src/seg_display.sv
src/jtag_mem_top.sv
sim/jtag_mem_properties.sv
sim/tb_jtag_mem_top.sv

// File: Makefile
VERILATOR  = verilator
TOP        = tb_jtag_mem_top
FILELIST   = vlog.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -Mdir $(OBJ_DIR)
PASS_MSG   = All tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
